// File: hdl/cpu_pkg.sv
package cpu_pkg;

    // datapath and instruction word width
    localparam int word_w = 16;
    // address field of an instruction, 2048 words at most
    localparam int addr_w = 11;
    // immediate field of a control instruction
    localparam int imm_w = 12;

    typedef logic [word_w-1:0] word_t;
    typedef logic [addr_w-1:0] addr_t;

    // instruction format
    //   bit 15 set   -> alu instruction
    //     [14:11] alu_op_t, [10:0] operand address
    //   bit 15 clear -> control instruction
    //     [14:12] ctrl_op_t, [11:0] immediate or address
    //     addresses use only the low 11 bits of the field

    // arithmetic rules
    //   mul keeps the low 16 bits of the product
    //   division by zero gives all ones
    //   gt and eq give 1 or 0
    //   shifts and rotates move by one, operand ignored

    // alu opcodes, arithmetic and shifts first, then logic and compares
    typedef enum logic [3:0] {
        alu_add  = 4'h0,
        alu_sub  = 4'h1,
        alu_mul  = 4'h2,
        alu_div  = 4'h3,
        alu_shl  = 4'h4,
        alu_shr  = 4'h5,
        alu_rol  = 4'h6,
        alu_ror  = 4'h7,
        alu_and  = 4'h8,
        alu_or   = 4'h9,
        alu_xor  = 4'ha,
        alu_nor  = 4'hb,
        alu_nand = 4'hc,
        alu_xnor = 4'hd,
        alu_gt   = 4'he,
        alu_eq   = 4'hf
    } alu_op_t;

    // control opcodes, bit 15 clear
    typedef enum logic [2:0] {
        ctrl_load  = 3'd0,
        ctrl_store = 3'd1,
        ctrl_loadi = 3'd2,
        ctrl_jump  = 3'd3,
        ctrl_jz    = 3'd4,
        ctrl_out   = 3'd5,
        ctrl_halt  = 3'd6,
        ctrl_nop   = 3'd7
    } ctrl_op_t;

    // field extraction
    function automatic logic instr_is_alu(word_t instr);
        return instr[word_w-1];
    endfunction

    function automatic alu_op_t instr_alu_op(word_t instr);
        return alu_op_t'(instr[14:11]);
    endfunction

    function automatic ctrl_op_t instr_ctrl_op(word_t instr);
        return ctrl_op_t'(instr[14:12]);
    endfunction

    function automatic addr_t instr_addr(word_t instr);
        return instr[addr_w-1:0];
    endfunction

    // zero-extended immediate
    function automatic word_t instr_imm(word_t instr);
        return word_t'(instr[imm_w-1:0]);
    endfunction

endpackage

// File: hdl/alu.sv
`timescale 1ns/1ps

module alu (
    input  cpu_pkg::alu_op_t op,
    input  cpu_pkg::word_t   a,
    input  cpu_pkg::word_t   b,
    output cpu_pkg::word_t   result
);
    import cpu_pkg::*;

    // a is the accumulator, b the memory operand
    always_comb begin
        unique case (op)
            alu_add:  result = a + b;
            alu_sub:  result = a - b;
            // low half of the product only
            alu_mul:  result = a * b;
            alu_div: begin
                // divide by zero saturates to all ones
                if (b == '0) begin
                    result = '1;
                end else begin
                    result = a / b;
                end
            end
            // single-bit shifts, b unused
            alu_shl:  result = a << 1;
            alu_shr:  result = a >> 1;
            alu_rol:  result = {a[word_w-2:0], a[word_w-1]};
            alu_ror:  result = {a[0], a[word_w-1:1]};
            // bitwise group
            alu_and:  result = a & b;
            alu_or:   result = a | b;
            alu_xor:  result = a ^ b;
            alu_nor:  result = ~(a | b);
            alu_nand: result = ~(a & b);
            alu_xnor: result = ~(a ^ b);
            // compares, unsigned, give 1 or 0
            alu_gt: begin
                if (a > b) begin
                    result = word_t'(1);
                end else begin
                    result = '0;
                end
            end
            alu_eq: begin
                if (a == b) begin
                    result = word_t'(1);
                end else begin
                    result = '0;
                end
            end
            default:  result = '0;
        endcase
    end

endmodule

// File: hdl/main_memory.sv
`timescale 1ns/1ps

module main_memory #(
    parameter int mem_words = 1024
) (
    input  logic           clk,
    // processor port
    input  cpu_pkg::addr_t addr,
    input  logic           we,
    input  cpu_pkg::word_t wdata,
    output cpu_pkg::word_t rdata,
    // program load port, write only
    input  logic           load_we,
    input  cpu_pkg::addr_t load_addr,
    input  cpu_pkg::word_t load_data
);
    import cpu_pkg::*;

    // index width, upper address bits are dropped
    localparam int mem_aw = $clog2(mem_words);

    word_t mem [mem_words];

    always_ff @(posedge clk) begin
        // processor port: write when we, else registered read
        if (we) begin
            mem[addr[mem_aw-1:0]] <= wdata;
        end else begin
            rdata <= mem[addr[mem_aw-1:0]];
        end
        // load port writes on its own
        // it comes last, so the same address written by both ports keeps the load data
        if (load_we) begin
            mem[load_addr[mem_aw-1:0]] <= load_data;
        end
    end

endmodule

// File: hdl/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit #(
    parameter int mem_words = 1024
) (
    input  logic           clk,
    input  logic           reset,
    input  logic           start,
    // from execute
    input  logic           exec_done,
    input  logic           branch_taken,
    input  cpu_pkg::addr_t branch_target,
    input  logic           halt_req,
    input  cpu_pkg::addr_t exec_addr,
    input  logic           exec_we,
    input  cpu_pkg::word_t exec_wdata,
    // memory read data
    input  cpu_pkg::word_t mem_rdata,
    output logic           halted,
    // to execute
    output logic           instr_valid,
    output cpu_pkg::word_t instr,
    // memory port
    output cpu_pkg::addr_t mem_addr,
    output logic           mem_we,
    output cpu_pkg::word_t mem_wdata
);
    import cpu_pkg::*;

    // pc wraps within the memory depth
    localparam addr_t pc_mask = addr_t'(mem_words - 1);

    typedef enum logic [1:0] {
        ph_halted,
        ph_issue,
        ph_capture,
        ph_execute
    } phase_t;

    phase_t phase;
    addr_t  pc;
    addr_t  pc_next;

    // next pc, only used on exec_done
    assign pc_next = branch_taken ? (branch_target & pc_mask) : ((pc + 1'b1) & pc_mask);

    always_ff @(posedge clk) begin
        if (reset) begin
            phase       <= ph_halted;
            pc          <= '0;
            instr_valid <= 1'b0;
        end else begin
            instr_valid <= 1'b0;
            unique case (phase)
                ph_halted: begin
                    // every run begins at address 0
                    if (start) begin
                        phase <= ph_issue;
                        pc    <= '0;
                    end
                end
                // pc on the bus, read in flight
                ph_issue: begin
                    phase <= ph_capture;
                end
                // read data lands in ir
                ph_capture: begin
                    phase       <= ph_execute;
                    instr_valid <= 1'b1;
                end
                ph_execute: begin
                    if (halt_req) begin
                        phase <= ph_halted;
                    end else if (exec_done) begin
                        pc    <= pc_next;
                        phase <= ph_issue;
                    end
                end
                default: phase <= ph_halted;
            endcase
        end
    end

    // instruction register
    always_ff @(posedge clk) begin
        if (phase == ph_capture) begin
            instr <= mem_rdata;
        end
    end

    // memory port owner follows the phase
    always_comb begin
        if (phase == ph_execute) begin
            mem_addr  = exec_addr;
            mem_we    = exec_we;
            mem_wdata = exec_wdata;
        end else begin
            mem_addr  = pc;
            mem_we    = 1'b0;
            mem_wdata = '0;
        end
    end

    assign halted = (phase == ph_halted);

endmodule

// File: hdl/execute_unit.sv
`timescale 1ns/1ps

module execute_unit (
    input  logic             clk,
    input  logic             reset,
    // from fetch
    input  logic             instr_valid,
    input  cpu_pkg::word_t   instr,
    // operand and alu result
    input  cpu_pkg::word_t   mem_rdata,
    input  cpu_pkg::word_t   alu_result,
    output cpu_pkg::alu_op_t alu_op,
    output cpu_pkg::word_t   acc,
    // memory request, forwarded by fetch
    output cpu_pkg::addr_t   exec_addr,
    output logic             exec_we,
    output cpu_pkg::word_t   exec_wdata,
    // end of instruction
    output logic             exec_done,
    output logic             branch_taken,
    output cpu_pkg::addr_t   branch_target,
    output logic             halt_req,
    // output strobe
    output logic             out_valid,
    output cpu_pkg::word_t   out_data
);
    import cpu_pkg::*;

    // st_exec is the cycle after instr_valid
    // st_operand is the cycle read data is valid
    typedef enum logic [1:0] {
        st_idle,
        st_exec,
        st_operand
    } step_t;

    step_t    step;

    logic     is_alu;
    ctrl_op_t ctrl_op;
    logic     is_load;
    logic     is_store;
    logic     is_loadi;
    logic     is_jump;
    logic     is_jz;
    logic     is_out;
    logic     is_halt;
    logic     needs_operand;
    logic     acc_zero;

    // decode, ir stays put for the whole execute phase
    assign is_alu   = instr_is_alu(instr);
    assign ctrl_op  = instr_ctrl_op(instr);
    assign is_load  = !is_alu && (ctrl_op == ctrl_load);
    assign is_store = !is_alu && (ctrl_op == ctrl_store);
    assign is_loadi = !is_alu && (ctrl_op == ctrl_loadi);
    assign is_jump  = !is_alu && (ctrl_op == ctrl_jump);
    assign is_jz    = !is_alu && (ctrl_op == ctrl_jz);
    assign is_out   = !is_alu && (ctrl_op == ctrl_out);
    assign is_halt  = !is_alu && (ctrl_op == ctrl_halt);

    // load and alu ops wait one cycle for the operand
    assign needs_operand = is_alu || is_load;
    assign acc_zero      = (acc == '0);

    assign alu_op = instr_alu_op(instr);

    always_ff @(posedge clk) begin
        if (reset) begin
            step <= st_idle;
            acc  <= '0;
        end else begin
            unique case (step)
                st_idle: begin
                    if (instr_valid) begin
                        step <= st_exec;
                    end
                end
                st_exec: begin
                    if (needs_operand) begin
                        step <= st_operand;
                    end else begin
                        step <= st_idle;
                    end
                    if (is_loadi) begin
                        acc <= instr_imm(instr);
                    end
                end
                st_operand: begin
                    step <= st_idle;
                    // load takes the raw word
                    if (is_alu) begin
                        acc <= alu_result;
                    end else begin
                        acc <= mem_rdata;
                    end
                end
                default: step <= st_idle;
            endcase
        end
    end

    // address held from the start of execute, so the read is early
    assign exec_addr  = instr_addr(instr);
    assign exec_wdata = acc;
    assign exec_we    = (step == st_exec) && is_store;

    // halt ends the instruction through halt_req instead
    assign exec_done = ((step == st_exec) && !needs_operand && !is_halt)
                    || (step == st_operand);
    assign halt_req  = (step == st_exec) && is_halt;

    // branch info qualified by exec_done at fetch
    assign branch_taken  = is_jump || (is_jz && acc_zero);
    assign branch_target = instr_addr(instr);

    assign out_valid = (step == st_exec) && is_out;
    assign out_data  = acc;

endmodule

// File: hdl/cpu_top.sv
`timescale 1ns/1ps

module cpu_top #(
    parameter int mem_words = 1024
) (
    input  logic           clk,
    input  logic           reset,
    // program load, only while halted
    input  logic           prog_we,
    input  cpu_pkg::addr_t prog_addr,
    input  cpu_pkg::word_t prog_data,
    // run control
    input  logic           start,
    output logic           halted,
    // output strobe
    output logic           out_valid,
    output cpu_pkg::word_t out_data
);
    import cpu_pkg::*;

    // fetch to execute
    logic    instr_valid;
    word_t   instr;

    // execute to fetch
    logic    exec_done;
    logic    branch_taken;
    addr_t   branch_target;
    logic    halt_req;
    addr_t   exec_addr;
    logic    exec_we;
    word_t   exec_wdata;

    // memory port
    addr_t   mem_addr;
    logic    mem_we;
    word_t   mem_wdata;
    word_t   mem_rdata;

    // alu
    alu_op_t alu_op;
    word_t   acc;
    word_t   alu_result;

    fetch_unit #(
        .mem_words(mem_words)
    ) u_fetch (
        .clk          (clk),
        .reset        (reset),
        .start        (start),
        .exec_done    (exec_done),
        .branch_taken (branch_taken),
        .branch_target(branch_target),
        .halt_req     (halt_req),
        .exec_addr    (exec_addr),
        .exec_we      (exec_we),
        .exec_wdata   (exec_wdata),
        .mem_rdata    (mem_rdata),
        .halted       (halted),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .mem_addr     (mem_addr),
        .mem_we       (mem_we),
        .mem_wdata    (mem_wdata)
    );

    execute_unit u_exec (
        .clk          (clk),
        .reset        (reset),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .mem_rdata    (mem_rdata),
        .alu_result   (alu_result),
        .alu_op       (alu_op),
        .acc          (acc),
        .exec_addr    (exec_addr),
        .exec_we      (exec_we),
        .exec_wdata   (exec_wdata),
        .exec_done    (exec_done),
        .branch_taken (branch_taken),
        .branch_target(branch_target),
        .halt_req     (halt_req),
        .out_valid    (out_valid),
        .out_data     (out_data)
    );

    // accumulator against the memory operand
    alu u_alu (
        .op    (alu_op),
        .a     (acc),
        .b     (mem_rdata),
        .result(alu_result)
    );

    main_memory #(
        .mem_words(mem_words)
    ) u_mem (
        .clk      (clk),
        .addr     (mem_addr),
        .we       (mem_we),
        .wdata    (mem_wdata),
        .rdata    (mem_rdata),
        .load_we  (prog_we),
        .load_addr(prog_addr),
        .load_data(prog_data)
    );

endmodule

// File: tests/cpu_model.svh
`ifndef CPU_MODEL_SVH
`define CPU_MODEL_SVH

// instruction-set model, expects mem_words and cpu_pkg in scope
word_t m_mem [mem_words];
word_t m_acc;
// expected out values, oldest first
word_t exp_q [$];

// alu instruction: bit 15 set, op, operand address
function automatic word_t alu_instr(alu_op_t op, int addr);
    return {1'b1, op, addr_t'(addr)};
endfunction

// control instruction: bit 15 clear, op, 12-bit field
function automatic word_t ctrl_instr(ctrl_op_t op, int field);
    logic [11:0] f;
    f = field[11:0];
    return {1'b0, op, f};
endfunction

// arithmetic rules straight from the instruction set
function automatic word_t alu_model(logic [3:0] op, word_t a, word_t b);
    case (op)
        4'h0: return a + b;
        4'h1: return a - b;
        // low 16 bits of the product
        4'h2: return a * b;
        4'h3: return (b == 0) ? 16'hffff : a / b;
        4'h4: return a << 1;
        4'h5: return a >> 1;
        4'h6: return {a[14:0], a[15]};
        4'h7: return {a[0], a[15:1]};
        4'h8: return a & b;
        4'h9: return a | b;
        4'ha: return a ^ b;
        4'hb: return ~(a | b);
        4'hc: return ~(a & b);
        4'hd: return ~(a ^ b);
        4'he: return (a > b) ? 16'd1 : 16'd0;
        default: return (a == b) ? 16'd1 : 16'd0;
    endcase
endfunction

// runs from address 0 until halt, acc and memory carry over
task automatic model_run(output int steps);
    int pc;
    int a;
    word_t w;
    bit done;
    pc = 0;
    steps = 0;
    done = 0;
    // step cap keeps a runaway program finite
    while (!done && steps < 100000) begin
        w = m_mem[pc];
        a = w[10:0] % mem_words;
        pc = (pc + 1) % mem_words;
        steps++;
        if (w[15]) begin
            m_acc = alu_model(w[14:11], m_acc, m_mem[a]);
        end else begin
            case (w[14:12])
                ctrl_load:  m_acc = m_mem[a];
                ctrl_store: m_mem[a] = m_acc;
                ctrl_loadi: m_acc = {4'h0, w[11:0]};
                ctrl_jump:  pc = a;
                ctrl_jz: begin
                    if (m_acc == 0) begin
                        pc = a;
                    end
                end
                ctrl_out:   exp_q.push_back(m_acc);
                ctrl_halt:  done = 1;
                default:    ;
            endcase
        end
    end
endtask

`endif

// File: tests/cpu_tb.sv
`timescale 1ns/1ps

module cpu_tb;
    import cpu_pkg::*;

    localparam int mem_words = 1024;

    logic  clk;
    logic  reset;
    logic  prog_we;
    addr_t prog_addr;
    word_t prog_data;
    logic  start;
    logic  halted;
    logic  out_valid;
    word_t out_data;

    string cur_test;
    int    val_errs;
    int    misc_errs;
    // load cycles since the last run, part of the timeout budget
    int    load_cycles;

    `include "cpu_model.svh"

    cpu_top #(
        .mem_words(mem_words)
    ) i_dut (
        .clk      (clk),
        .reset    (reset),
        .prog_we  (prog_we),
        .prog_addr(prog_addr),
        .prog_data(prog_data),
        .start    (start),
        .halted   (halted),
        .out_valid(out_valid),
        .out_data (out_data)
    );

    // 4 ns clock
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check_value(string name, word_t exp, word_t got);
        assert (got === exp) else begin
            $display("ERR %s: expected %h, actual %h", name, exp, got);
            val_errs++;
        end
    endtask

    // output monitor, pre-edge values at posedge
    always @(posedge clk) begin
        if (out_valid === 1'b1) begin
            assert (exp_q.size() > 0) else begin
                $display("%s: output %h came when none was expected", cur_test, out_data);
                misc_errs++;
            end
            if (exp_q.size() > 0) begin
                check_value(cur_test, exp_q.pop_front(), out_data);
            end
        end
    end

    // one word through the load port, mirrored into the model
    task automatic load_word(int addr, word_t data);
        prog_we   = 1'b1;
        prog_addr = addr_t'(addr);
        prog_data = data;
        m_mem[addr % mem_words] = data;
        @(negedge clk);
        prog_we = 1'b0;
        load_cycles++;
    endtask

    task automatic run_test(string name);
        int steps;
        int limit;
        int cycles;
        cur_test = name;
        model_run(steps);
        // about 4 cycles per instruction, the margin covers load and alu ops
        limit = steps * 4 + load_cycles + 100;
        load_cycles = 0;
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        @(negedge clk);
        check_value(name, 0, halted);
        cycles = 0;
        while (halted !== 1'b1 && cycles < limit) begin
            @(negedge clk);
            cycles++;
        end
        if (halted !== 1'b1) begin
            misc_errs++;
            $display("timeout: %s did not halt within %0d cycles", name, limit);
            $display("errors: %0d value mismatches, %0d other failures", val_errs, misc_errs);
            $display("Test failures found");
            $finish;
        end
        // nothing may come out after halt
        repeat (10) @(negedge clk);
        assert (exp_q.size() == 0) else begin
            $display("%s: %0d expected outputs never appeared", name, exp_q.size());
            misc_errs++;
            exp_q.delete();
        end
    endtask

    // each op behind load or loadi, result strobed out
    task automatic sweep_alu_ops();
        int pc;
        int op;
        int da;
        word_t va;
        word_t vb;
        pc = 0;
        for (int i = 0; i < 20; i++) begin
            if (i < 16) begin
                op = i;
            end else if (i == 16) begin
                op = alu_div;
            end else if (i == 17) begin
                op = alu_eq;
            end else begin
                op = $urandom_range(0, 15);
            end
            da = 512 + 2 * i;
            va = word_t'($urandom);
            vb = word_t'($urandom);
            // divide by zero, then an equal compare
            if (i == 16) begin
                vb = '0;
            end
            if (i == 17) begin
                vb = {4'h0, va[11:0]};
            end
            load_word(da, va);
            load_word(da + 1, vb);
            if (i % 2) begin
                load_word(pc, ctrl_instr(ctrl_loadi, va[11:0]));
            end else begin
                load_word(pc, ctrl_instr(ctrl_load, da));
            end
            load_word(pc + 1, alu_instr(alu_op_t'(op), da + 1));
            load_word(pc + 2, ctrl_instr(ctrl_out, 0));
            pc += 3;
        end
        load_word(pc, ctrl_instr(ctrl_halt, 0));
        run_test("alu_ops");
    endtask

    task automatic store_load_roundtrip();
        int pc;
        int v;
        int a;
        pc = 0;
        for (int i = 0; i < 8; i++) begin
            v = $urandom_range(0, 4095);
            a = $urandom_range(600, 899);
            load_word(pc, ctrl_instr(ctrl_loadi, v));
            load_word(pc + 1, ctrl_instr(ctrl_store, a));
            // clear acc so the load shows
            load_word(pc + 2, ctrl_instr(ctrl_loadi, 0));
            load_word(pc + 3, ctrl_instr(ctrl_load, a));
            load_word(pc + 4, ctrl_instr(ctrl_out, 0));
            pc += 5;
        end
        load_word(pc, ctrl_instr(ctrl_halt, 0));
        run_test("store_load");
    endtask

    // countdown loop, then a jz that must fall through
    task automatic countdown_loop();
        int n;
        n = $urandom_range(3, 8);
        load_word(950, 16'd1);
        load_word(0, ctrl_instr(ctrl_loadi, n));
        load_word(1, ctrl_instr(ctrl_out, 0));
        load_word(2, alu_instr(alu_sub, 950));
        load_word(3, ctrl_instr(ctrl_jz, 5));
        load_word(4, ctrl_instr(ctrl_jump, 1));
        load_word(5, ctrl_instr(ctrl_out, 0));
        load_word(6, ctrl_instr(ctrl_loadi, 5));
        load_word(7, ctrl_instr(ctrl_jz, 10));
        load_word(8, ctrl_instr(ctrl_out, 0));
        load_word(9, ctrl_instr(ctrl_halt, 0));
        load_word(10, ctrl_instr(ctrl_halt, 0));
        run_test("branch");
    endtask

    task automatic halt_restart();
        int x;
        x = $urandom_range(1, 4095);
        load_word(0, ctrl_instr(ctrl_loadi, x));
        load_word(1, ctrl_instr(ctrl_out, 0));
        load_word(2, ctrl_instr(ctrl_halt, 0));
        // never reached
        load_word(3, ctrl_instr(ctrl_out, 0));
        run_test("halt");
        // second program starts with the old acc
        load_word(960, word_t'($urandom));
        load_word(0, ctrl_instr(ctrl_out, 0));
        load_word(1, alu_instr(alu_add, 960));
        load_word(2, ctrl_instr(ctrl_out, 0));
        load_word(3, ctrl_instr(ctrl_halt, 0));
        run_test("restart");
    endtask

    // nops at the top of memory run into the out at address 0
    task automatic pc_wraparound();
        int top;
        top = mem_words - 8;
        load_word(970, 16'd0);
        load_word(0, ctrl_instr(ctrl_out, 0));
        load_word(1, ctrl_instr(ctrl_load, 970));
        load_word(2, ctrl_instr(ctrl_jz, 4));
        load_word(3, ctrl_instr(ctrl_halt, 0));
        load_word(4, ctrl_instr(ctrl_loadi, 7));
        load_word(5, ctrl_instr(ctrl_store, 970));
        load_word(6, ctrl_instr(ctrl_jump, top));
        for (int i = top; i < mem_words; i++) begin
            load_word(i, ctrl_instr(ctrl_nop, 0));
        end
        run_test("pc_wrap");
    endtask

    initial begin
        reset       = 1'b1;
        prog_we     = 1'b0;
        prog_addr   = '0;
        prog_data   = '0;
        start       = 1'b0;
        val_errs    = 0;
        misc_errs   = 0;
        load_cycles = 0;
        cur_test    = "reset";
        m_acc       = '0;
        void'($urandom(32'h1363692a));
        repeat (5) @(negedge clk);
        reset = 1'b0;
        // idle and halted until the first start
        repeat (5) begin
            @(negedge clk);
            check_value("reset", 1, halted);
            check_value("reset", 0, out_valid);
        end
        sweep_alu_ops();
        store_load_roundtrip();
        countdown_loop();
        halt_restart();
        pc_wraparound();
        $display("errors: %0d value mismatches, %0d other failures", val_errs, misc_errs);
        if (val_errs + misc_errs == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: Bender.yml
package:
  name: acc_cpu

sources:
  - hdl/cpu_pkg.sv
  - hdl/alu.sv
  - hdl/main_memory.sv
  - hdl/fetch_unit.sv
  - hdl/execute_unit.sv
  - hdl/cpu_top.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/cpu_tb.sv

// File: build.f
+incdir+tests
hdl/cpu_pkg.sv
hdl/alu.sv
hdl/main_memory.sv
hdl/fetch_unit.sv
hdl/execute_unit.sv
hdl/cpu_top.sv
tests/cpu_tb.sv
